//--- common/tcb_lite_pkg.sv
/*
 * TCB-Lite shared definitions
 * bus widths, request and response structs, manager index type
 */

package tcb_lite_pkg;

    //////////////////////////////////////////////////
    // bus widths
    //////////////////////////////////////////////////

    localparam int unsigned tcb_dat_w = 32;              // data width
    localparam int unsigned tcb_adr_w = 32;              // address width
    localparam int unsigned tcb_byt_w = tcb_dat_w/8;     // byte lanes
    localparam int unsigned tcb_siz_w = $clog2(tcb_byt_w);  // log size width

    //////////////////////////////////////////////////
    // request and response
    //////////////////////////////////////////////////

    // request, 73 bits, field order as on the flat ports
    typedef struct packed {
        logic                 lck;  // arbitration lock
        logic                 ndn;  // endianness, 0 little, 1 big
        logic                 wen;  // write enable
        logic [tcb_adr_w-1:0] adr;  // address
        logic [tcb_siz_w-1:0] siz;  // transfer size, carried only
        logic [tcb_byt_w-1:0] byt;  // byte enables
        logic [tcb_dat_w-1:0] wdt;  // write data
    } tcb_req_t;

    // response, 33 bits
    typedef struct packed {
        logic [tcb_dat_w-1:0] rdt;  // read data
        logic                 err;  // bus error
    } tcb_rsp_t;

    // which of the two managers
    typedef logic [0:0] tcb_mgr_idx_t;

endpackage: tcb_lite_pkg

//--- interconnect/tcb_lite_arbiter.sv
/*
 * two-to-one round-robin arbiter with arbitration lock
 * grant held under back-pressure, response routed by delayed index
 */

`timescale 1ns/100ps

module tcb_lite_arbiter #(
    parameter int unsigned DLY = 1  // response delay in cycles
)(
    input  logic                   clk,
    input  logic                   rst_n,
    // one port per manager
    input  logic                   sub_vld [2],
    output logic                   sub_rdy [2],
    input  tcb_lite_pkg::tcb_req_t sub_req [2],
    output tcb_lite_pkg::tcb_rsp_t sub_rsp [2],
    // shared downstream port
    output logic                   man_vld,
    input  logic                   man_rdy,
    output tcb_lite_pkg::tcb_req_t man_req,
    input  tcb_lite_pkg::tcb_rsp_t man_rsp
);

    import tcb_lite_pkg::*;

    tcb_mgr_idx_t pri;              // manager with priority
    logic         lck_on;           // locked sequence open for pri
    tcb_mgr_idx_t gnt;              // current grant
    logic         trn;              // transfer on the shared port
    tcb_mgr_idx_t idx_dly [DLY];    // granted index, one entry per cycle

    //////////////////////////////////////////////////
    // grant
    //////////////////////////////////////////////////

    always_comb begin
        if (lck_on) begin
            gnt     = pri;              // lock owner only
            man_vld = sub_vld[pri];
        end else begin
            gnt     = sub_vld[pri] ? pri : ~pri;
            man_vld = sub_vld[0] | sub_vld[1];
        end
        man_req = sub_req[gnt];
    end

    // rdy back to the winner only
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            sub_rdy[i] = man_rdy & (gnt == tcb_mgr_idx_t'(i));
        end
    end

    assign trn = man_vld & man_rdy;

    // priority and lock state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pri    <= '0;
            lck_on <= 1'b0;
        end else if (trn) begin
            lck_on <= man_req.lck;                  // lck=0 closes the sequence
            pri    <= man_req.lck ? gnt : ~gnt;     // rotate unless locked
        end else if (man_vld) begin
            pri    <= gnt;  // stalled, keep the same winner next cycle
        end
    end

    //////////////////////////////////////////////////
    // response routing
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DLY; i++) begin
                idx_dly[i] <= '0;
            end
        end else begin
            idx_dly[0] <= gnt;
            for (int i = 1; i < DLY; i++) begin
                idx_dly[i] <= idx_dly[i-1];  // shift toward the output
            end
        end
    end

    // other manager sees an idle response
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            sub_rsp[i] = (idx_dly[DLY-1] == tcb_mgr_idx_t'(i)) ? man_rsp : '0;
        end
    end

endmodule: tcb_lite_arbiter

//--- interconnect/tcb_lite_decoder.sv
/*
 * one-to-two address decoder
 * local bus error responder for addresses outside the window
 */

`timescale 1ns/100ps

module tcb_lite_decoder #(
    parameter int unsigned DLY     = 1,   // response delay in cycles
    parameter int unsigned SEL_BIT = 12   // address bit picking the peripheral
)(
    input  logic                   clk,
    input  logic                   rst_n,
    // upstream port
    input  logic                   sub_vld,
    output logic                   sub_rdy,
    input  tcb_lite_pkg::tcb_req_t sub_req,
    output tcb_lite_pkg::tcb_rsp_t sub_rsp,
    // peripheral ports
    output logic                   man_vld [2],
    input  logic                   man_rdy [2],
    output tcb_lite_pkg::tcb_req_t man_req [2],
    input  tcb_lite_pkg::tcb_rsp_t man_rsp [2]
);

    import tcb_lite_pkg::*;

    // address bits above the select bit
    localparam logic [tcb_adr_w-1:0] win_msk = {tcb_adr_w{1'b1}} << (SEL_BIT+1);

    typedef struct packed {
        logic err;  // decode error
        logic sel;  // peripheral index
    } dec_t;

    dec_t dec;              // decode of the current request
    dec_t dec_dly [DLY];    // decode per cycle, oldest last
    logic trn;

    //////////////////////////////////////////////////
    // request routing
    //////////////////////////////////////////////////

    always_comb begin
        dec.sel = sub_req.adr[SEL_BIT];
        dec.err = |(sub_req.adr & win_msk);
        for (int j = 0; j < 2; j++) begin
            man_vld[j] = sub_vld & ~dec.err & (dec.sel == 1'(j));
            man_req[j] = sub_req;   // vld tells which one is live
        end
        sub_rdy = dec.err | man_rdy[dec.sel];   // errors accepted at once
    end

    assign trn = sub_vld & sub_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DLY; i++) begin
                dec_dly[i] <= '0;
            end
        end else begin
            dec_dly[0] <= '{err: trn & dec.err, sel: dec.sel};
            for (int i = 1; i < DLY; i++) begin
                dec_dly[i] <= dec_dly[i-1];
            end
        end
    end

    // response merge
    always_comb begin
        if (dec_dly[DLY-1].err) begin
            sub_rsp.rdt = '0;
            sub_rsp.err = 1'b1;
        end else begin
            sub_rsp = man_rsp[dec_dly[DLY-1].sel];
        end
    end

endmodule: tcb_lite_decoder

//--- source/tcb_lite_endian.sv
/*
 * endianness converter, big-endian requests to little-endian lanes
 * read data lanes swapped back after the response delay
 */

`timescale 1ns/100ps

module tcb_lite_endian #(
    parameter int unsigned DLY = 1  // response delay in cycles
)(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sub_vld,
    output logic                   sub_rdy,
    input  tcb_lite_pkg::tcb_req_t sub_req,
    output tcb_lite_pkg::tcb_rsp_t sub_rsp,
    output logic                   man_vld,
    input  logic                   man_rdy,
    output tcb_lite_pkg::tcb_req_t man_req,
    input  tcb_lite_pkg::tcb_rsp_t man_rsp
);

    import tcb_lite_pkg::*;

    logic swp_dly [DLY];  // swap flag per cycle

    // reverse byte lanes of a data word
    function automatic logic [tcb_dat_w-1:0] swap_dat(input logic [tcb_dat_w-1:0] dat);
        logic [tcb_dat_w-1:0] tmp;
        for (int b = 0; b < tcb_byt_w; b++) begin
            tmp[8*b +: 8] = dat[8*(tcb_byt_w-1-b) +: 8];
        end
        return tmp;
    endfunction

    // same for the byte enables
    function automatic logic [tcb_byt_w-1:0] swap_byt(input logic [tcb_byt_w-1:0] byt);
        logic [tcb_byt_w-1:0] tmp;
        for (int b = 0; b < tcb_byt_w; b++) begin
            tmp[b] = byt[tcb_byt_w-1-b];
        end
        return tmp;
    endfunction

    always_comb begin
        man_vld = sub_vld;
        sub_rdy = man_rdy;
        man_req = sub_req;
        if (sub_req.ndn) begin
            man_req.ndn = 1'b0;                     // peripherals are little-endian
            man_req.wdt = swap_dat(sub_req.wdt);
            man_req.byt = swap_byt(sub_req.byt);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DLY; i++) swp_dly[i] <= 1'b0;
        end else begin
            swp_dly[0] <= sub_vld & sub_rdy & sub_req.ndn;  // only real transfers
            for (int i = 1; i < DLY; i++) swp_dly[i] <= swp_dly[i-1];
        end
    end

    assign sub_rsp.rdt = swp_dly[DLY-1] ? swap_dat(man_rsp.rdt) : man_rsp.rdt;
    assign sub_rsp.err = man_rsp.err;

endmodule: tcb_lite_endian

//--- source/tcb_lite_interconnect.sv
/*
 * TCB-Lite interconnect top, two managers to two peripherals
 * flat ports packed into structs, arbiter then endian converter then decoder
 */

`timescale 1ns/100ps

module tcb_lite_interconnect #(
    parameter int unsigned DLY     = 1,   // response delay
    parameter int unsigned SEL_BIT = 12   // peripheral select bit
)(
    input  logic                                 clk,
    input  logic                                 rst_n,
    // manager side
    input  logic                                 sub_vld     [2],
    output logic                                 sub_rdy     [2],
    input  logic                                 sub_req_lck [2],
    input  logic                                 sub_req_ndn [2],
    input  logic                                 sub_req_wen [2],
    input  logic [tcb_lite_pkg::tcb_adr_w-1:0]   sub_req_adr [2],
    input  logic [tcb_lite_pkg::tcb_siz_w-1:0]   sub_req_siz [2],
    input  logic [tcb_lite_pkg::tcb_byt_w-1:0]   sub_req_byt [2],
    input  logic [tcb_lite_pkg::tcb_dat_w-1:0]   sub_req_wdt [2],
    output logic [tcb_lite_pkg::tcb_dat_w-1:0]   sub_rsp_rdt [2],
    output logic                                 sub_rsp_err [2],
    // peripheral side
    output logic                                 man_vld     [2],
    input  logic                                 man_rdy     [2],
    output logic                                 man_req_lck [2],
    output logic                                 man_req_ndn [2],
    output logic                                 man_req_wen [2],
    output logic [tcb_lite_pkg::tcb_adr_w-1:0]   man_req_adr [2],
    output logic [tcb_lite_pkg::tcb_siz_w-1:0]   man_req_siz [2],
    output logic [tcb_lite_pkg::tcb_byt_w-1:0]   man_req_byt [2],
    output logic [tcb_lite_pkg::tcb_dat_w-1:0]   man_req_wdt [2],
    input  logic [tcb_lite_pkg::tcb_dat_w-1:0]   man_rsp_rdt [2],
    input  logic                                 man_rsp_err [2]
);

    import tcb_lite_pkg::*;

    tcb_req_t sub_req [2];  // packed manager requests
    tcb_rsp_t sub_rsp [2];
    tcb_req_t man_req [2];  // packed peripheral requests
    tcb_rsp_t man_rsp [2];
    logic     arb_vld, arb_rdy, dec_vld, dec_rdy;  // chain handshakes
    tcb_req_t arb_req, dec_req;
    tcb_rsp_t arb_rsp, dec_rsp;

    //////////////////////////////////////////////////
    // port packing
    //////////////////////////////////////////////////

    for (genvar i = 0; i < 2; i++) begin: g_port
        assign sub_req[i] = '{lck: sub_req_lck[i], ndn: sub_req_ndn[i], wen: sub_req_wen[i],
                              adr: sub_req_adr[i], siz: sub_req_siz[i], byt: sub_req_byt[i],
                              wdt: sub_req_wdt[i]};
        assign sub_rsp_rdt[i] = sub_rsp[i].rdt;
        assign sub_rsp_err[i] = sub_rsp[i].err;
        assign {man_req_lck[i], man_req_ndn[i], man_req_wen[i], man_req_adr[i],
                man_req_siz[i], man_req_byt[i], man_req_wdt[i]} = man_req[i];
        assign man_rsp[i] = '{rdt: man_rsp_rdt[i], err: man_rsp_err[i]};
    end: g_port

    //////////////////////////////////////////////////
    // request chain
    //////////////////////////////////////////////////

    tcb_lite_arbiter #(.DLY (DLY)) i_arbiter (
        .clk (clk), .rst_n (rst_n),
        .sub_vld (sub_vld), .sub_rdy (sub_rdy), .sub_req (sub_req), .sub_rsp (sub_rsp),
        .man_vld (arb_vld), .man_rdy (arb_rdy), .man_req (arb_req), .man_rsp (arb_rsp)
    );

    tcb_lite_endian #(.DLY (DLY)) i_endian (
        .clk (clk), .rst_n (rst_n),
        .sub_vld (arb_vld), .sub_rdy (arb_rdy), .sub_req (arb_req), .sub_rsp (arb_rsp),
        .man_vld (dec_vld), .man_rdy (dec_rdy), .man_req (dec_req), .man_rsp (dec_rsp)
    );

    tcb_lite_decoder #(.DLY (DLY), .SEL_BIT (SEL_BIT)) i_decoder (
        .clk (clk), .rst_n (rst_n),
        .sub_vld (dec_vld), .sub_rdy (dec_rdy), .sub_req (dec_req), .sub_rsp (dec_rsp),
        .man_vld (man_vld), .man_rdy (man_rdy), .man_req (man_req), .man_rsp (man_rsp)
    );

endmodule: tcb_lite_interconnect

//--- testbench/tcb_lite_interconnect_chk.sv
/*
 * protocol checker bound to the interconnect top
 * decode error, response timing, lock, round-robin, stability, byte swap,
 * request fields forwarded
 */

`timescale 1ns/100ps

module tcb_lite_interconnect_chk #(
    parameter int unsigned DLY     = 1,
    parameter int unsigned SEL_BIT = 12
)(
    input logic                               clk,
    input logic                               rst_n,
    input logic                               sub_vld     [2],
    input logic                               sub_rdy     [2],
    input logic                               sub_req_lck [2],
    input logic                               sub_req_ndn [2],
    input logic [tcb_lite_pkg::tcb_adr_w-1:0] sub_req_adr [2],
    input logic [tcb_lite_pkg::tcb_siz_w-1:0] sub_req_siz [2],
    input logic [tcb_lite_pkg::tcb_byt_w-1:0] sub_req_byt [2],
    input logic [tcb_lite_pkg::tcb_dat_w-1:0] sub_req_wdt [2],
    input logic [tcb_lite_pkg::tcb_dat_w-1:0] sub_rsp_rdt [2],
    input logic                               sub_rsp_err [2],
    input logic                               man_vld     [2],
    input logic                               man_rdy     [2],
    input logic                               man_req_lck [2],
    input logic                               man_req_ndn [2],
    input logic [tcb_lite_pkg::tcb_adr_w-1:0] man_req_adr [2],
    input logic [tcb_lite_pkg::tcb_siz_w-1:0] man_req_siz [2],
    input logic [tcb_lite_pkg::tcb_byt_w-1:0] man_req_byt [2],
    input logic [tcb_lite_pkg::tcb_dat_w-1:0] man_req_wdt [2]
);

    int unsigned fail_cnt = 0;  // read by the testbench
    logic        lck_open [2];  // locked sequence per manager

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lck_open[0] <= 1'b0;
            lck_open[1] <= 1'b0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (sub_vld[i] && sub_rdy[i]) lck_open[i] <= sub_req_lck[i];
            end
        end
    end

    //////////////////////////////////////////////////
    // per manager
    //////////////////////////////////////////////////

    for (genvar i = 0; i < 2; i++) begin: g_mgr
        localparam int o = 1 - i;  // the other manager
        logic trn;
        logic bad;
        assign trn = sub_vld[i] & sub_rdy[i];
        assign bad = (sub_req_adr[i] >> (SEL_BIT+1)) != '0;  // any bit above the select bit

        // out of window, nothing forwarded, err after DLY
        a_dec_err: assert property (@(posedge clk) disable iff (!rst_n)
            trn && bad |-> !man_vld[0] && !man_vld[1] ##DLY sub_rsp_err[i] && sub_rsp_rdt[i] == '0)
            else begin $error("decode error response wrong"); fail_cnt++; end

        a_rsp_ok: assert property (@(posedge clk) disable iff (!rst_n)
            trn && !bad |-> ##DLY !sub_rsp_err[i])
            else begin $error("unexpected bus error"); fail_cnt++; end

        // unlocked transfer hands priority over
        a_rr: assert property (@(posedge clk) disable iff (!rst_n)
            trn && !sub_req_lck[i] ##1 sub_vld[o] |-> !sub_rdy[i])
            else begin $error("round-robin order broken"); fail_cnt++; end

        a_lck: assert property (@(posedge clk) disable iff (!rst_n)
            lck_open[i] |-> !(sub_vld[o] && sub_rdy[o]))
            else begin $error("transfer from other manager inside lock"); fail_cnt++; end

        for (genvar j = 0; j < 2; j++) begin: g_swp
            // big-endian lanes reversed toward the peripheral
            a_swap: assert property (@(posedge clk) disable iff (!rst_n)
                trn && sub_req_ndn[i] && man_vld[j] |->
                    man_req_wdt[j] == {sub_req_wdt[i][7:0], sub_req_wdt[i][15:8],
                                       sub_req_wdt[i][23:16], sub_req_wdt[i][31:24]} &&
                    man_req_byt[j] == {sub_req_byt[i][0], sub_req_byt[i][1],
                                       sub_req_byt[i][2], sub_req_byt[i][3]})
                else begin $error("byte lanes not reversed"); fail_cnt++; end

            // lock, size and address carried through unchanged
            a_fwd: assert property (@(posedge clk) disable iff (!rst_n)
                trn && man_vld[j] |->
                    man_req_lck[j] == sub_req_lck[i] && man_req_siz[j] == sub_req_siz[i] &&
                    man_req_adr[j] == sub_req_adr[i])
                else begin $error("request fields not forwarded"); fail_cnt++; end
        end: g_swp
    end: g_mgr

    //////////////////////////////////////////////////
    // per peripheral
    //////////////////////////////////////////////////

    for (genvar j = 0; j < 2; j++) begin: g_per
        a_stable: assert property (@(posedge clk) disable iff (!rst_n)
            man_vld[j] && !man_rdy[j] |=> man_vld[j] && $stable(man_req_adr[j]) &&
                $stable(man_req_wdt[j]) && $stable(man_req_byt[j]))
            else begin $error("request changed under back-pressure"); fail_cnt++; end

        a_ndn: assert property (@(posedge clk) disable iff (!rst_n)
            man_vld[j] |-> !man_req_ndn[j])
            else begin $error("ndn not cleared toward peripheral"); fail_cnt++; end
    end: g_per

endmodule: tcb_lite_interconnect_chk

//--- testbench/tcb_lite_interconnect_tb.sv
/*
 * testbench for the TCB-Lite interconnect
 * managers, peripheral memory models, read-back checks, watchdog
 */

`timescale 1ns/100ps

module tcb_lite_interconnect_tb;

    import tcb_lite_pkg::*;

    localparam int unsigned DLY     = 1;
    localparam int unsigned SEL_BIT = 12;
    localparam int          n_tests = 6;
    localparam int          n_words = 2**(SEL_BIT-2);  // words per peripheral

    typedef struct {
        int          mgr;
        int          due;   // monitor cycle of the response
        logic [31:0] rdt;
        logic        err;
        logic        rdo;   // rdt is checked
    } exp_t;

    logic                 clk, rst_n;
    logic                 sub_vld [2], sub_rdy [2], sub_req_lck [2], sub_req_ndn [2];
    logic                 sub_req_wen [2], sub_rsp_err [2];
    logic [tcb_adr_w-1:0] sub_req_adr [2];
    logic [tcb_siz_w-1:0] sub_req_siz [2];
    logic [tcb_byt_w-1:0] sub_req_byt [2];
    logic [tcb_dat_w-1:0] sub_req_wdt [2], sub_rsp_rdt [2];
    logic                 man_vld [2], man_rdy [2], man_req_lck [2], man_req_ndn [2];
    logic                 man_req_wen [2], man_rsp_err [2];
    logic [tcb_adr_w-1:0] man_req_adr [2];
    logic [tcb_siz_w-1:0] man_req_siz [2];
    logic [tcb_byt_w-1:0] man_req_byt [2];
    logic [tcb_dat_w-1:0] man_req_wdt [2], man_rsp_rdt [2];

    integer      seed = 32'h7cb3_e9d9;
    int          err_cnt = 0;
    int          cyc = 0;
    logic [31:0] mdl_mem [2][n_words];  // peripheral models
    logic [31:0] exp_mem [2][n_words];  // expected contents
    logic [31:0] mpipe   [2][DLY];      // model read data in flight
    exp_t        exp_q [$];

    tcb_lite_interconnect #(.DLY (DLY), .SEL_BIT (SEL_BIT)) i_tcb_lite_interconnect (.*);

    bind tcb_lite_interconnect tcb_lite_interconnect_chk #(.DLY (DLY), .SEL_BIT (SEL_BIT))
        i_chk (.*);

    function automatic logic [31:0] rev_lanes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // fill value from the full byte address
    function automatic logic [31:0] fill_word(input int p, input int w);
        return ((32'(p) << SEL_BIT) | (32'(w) << 2)) * 32'h9e37_79b9 ^ 32'h5a5a_0f0f;
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // one request, returns after the transfer edge
    task automatic xfer(input int i, input bit wen, input bit lck, input bit ndn,
                        input logic [31:0] adr, input logic [3:0] byt, input logic [31:0] wdt);
        bit done;
        @(negedge clk);
        sub_vld[i]     = 1'b1;
        sub_req_wen[i] = wen;
        sub_req_lck[i] = lck;
        sub_req_ndn[i] = ndn;
        sub_req_adr[i] = adr;
        sub_req_byt[i] = byt;
        sub_req_wdt[i] = wdt;
        done = 1'b0;
        while (!done) begin
            #1 done = sub_rdy[i];
            if (!done) @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic idle(input int i);
        @(negedge clk);
        sub_vld[i]     = 1'b0;
        sub_req_lck[i] = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // memory models and response checks
    //////////////////////////////////////////////////

    initial begin
        exp_t        e;
        logic [31:0] adr, wd, rd;
        logic [3:0]  be;
        int          p, w;
        for (int j = 0; j < 2; j++) begin
            for (int k = 0; k < n_words; k++) begin
                mdl_mem[j][k] = fill_word(j, k);
                exp_mem[j][k] = fill_word(j, k);
            end
            for (int d = 0; d < DLY; d++) mpipe[j][d] = '0;
            man_rdy[j] = 1'b0;
            man_rsp_rdt[j] = '0;
            man_rsp_err[j] = 1'b0;
        end
        forever begin
            @(negedge clk);
            cyc++;
            for (int j = 0; j < 2; j++) begin
                man_rsp_rdt[j] = mpipe[j][DLY-1];
                for (int d = DLY-1; d > 0; d--) mpipe[j][d] = mpipe[j][d-1];
                mpipe[j][0] = '0;
                man_rdy[j] = ($random(seed) & 3) != 0;  // stall about one in four
            end
            #1;
            if (rst_n) begin
                while (exp_q.size() > 0 && exp_q[0].due == cyc) begin
                    e = exp_q.pop_front();
                    if (sub_rsp_err[e.mgr] !== e.err) begin
                        $display("MISMATCH %0t sub_rsp_err[%0d] got %b expected %b",
                                 $time, e.mgr, sub_rsp_err[e.mgr], e.err);
                        err_cnt++;
                    end
                    if (e.rdo && sub_rsp_rdt[e.mgr] !== e.rdt) begin
                        $display("MISMATCH %0t sub_rsp_rdt[%0d] got %h expected %h",
                                 $time, e.mgr, sub_rsp_rdt[e.mgr], e.rdt);
                        err_cnt++;
                    end
                end
                for (int i = 0; i < 2; i++) begin
                    if (sub_vld[i] && sub_rdy[i]) begin
                        adr = sub_req_adr[i];
                        p   = adr[SEL_BIT];
                        w   = adr[SEL_BIT-1:2];
                        wd  = sub_req_ndn[i] ? rev_lanes(sub_req_wdt[i]) : sub_req_wdt[i];
                        be  = sub_req_byt[i];
                        if (sub_req_ndn[i]) be = {be[0], be[1], be[2], be[3]};
                        e = '{mgr: i, due: cyc + DLY, rdt: '0, err: 1'b0, rdo: 1'b1};
                        if ((adr >> (SEL_BIT+1)) != 0) begin
                            e.err = 1'b1;  // outside the window
                        end else if (sub_req_wen[i]) begin
                            e.rdo = 1'b0;
                            for (int b = 0; b < 4; b++) begin
                                if (be[b]) exp_mem[p][w][8*b +: 8] = wd[8*b +: 8];
                            end
                        end else begin
                            rd = exp_mem[p][w];
                            e.rdt = sub_req_ndn[i] ? rev_lanes(rd) : rd;
                        end
                        exp_q.push_back(e);
                    end
                end
                for (int j = 0; j < 2; j++) begin
                    if (man_vld[j] && man_rdy[j]) begin
                        w = man_req_adr[j][SEL_BIT-1:2];
                        if (man_req_wen[j]) begin
                            for (int b = 0; b < 4; b++) begin
                                if (man_req_byt[j][b]) mdl_mem[j][w][8*b +: 8] = man_req_wdt[j][8*b +: 8];
                            end
                        end else begin
                            mpipe[j][0] = mdl_mem[j][w];
                        end
                    end
                end
            end
        end
    end

    // watchdog
    initial begin
        #(n_tests * 64 * 100);
        $display("timeout, run did not finish in time");
        $display("tests failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        int fails;
        rst_n = 1'b0;
        for (int i = 0; i < 2; i++) begin
            sub_vld[i] = 1'b0;
            sub_req_lck[i] = 1'b0;
            sub_req_ndn[i] = 1'b0;
            sub_req_wen[i] = 1'b0;
            sub_req_adr[i] = '0;
            sub_req_siz[i] = 2'd2;
            sub_req_byt[i] = '0;
            sub_req_wdt[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk) rst_n = 1'b1;

        // write and read-back, each manager to both peripherals
        for (int i = 0; i < 2; i++) begin
            for (int p = 0; p < 2; p++) begin
                xfer(i, 1, 0, 0, (p << SEL_BIT) | (i*16 + 32'h40), 4'hf, $random(seed));
                xfer(i, 1, 0, 0, (p << SEL_BIT) | (i*16 + 32'h44), 4'b0101, $random(seed));
                xfer(i, 0, 0, 0, (p << SEL_BIT) | (i*16 + 32'h40), 4'hf, '0);
                xfer(i, 0, 0, 0, (p << SEL_BIT) | (i*16 + 32'h44), 4'hf, '0);
                idle(i);
            end
        end

        // round-robin, both managers valid back to back
        fork
            begin
                for (int k = 0; k < 4; k++) xfer(0, 1, 0, 0, 32'h100 + 4*k, 4'hf, $random(seed));
                idle(0);
            end
            begin
                for (int k = 0; k < 4; k++) xfer(1, 1, 0, 0, 32'h1100 + 4*k, 4'hf, $random(seed));
                idle(1);
            end
        join

        // lock held across two transfers of manager 0
        fork
            begin
                xfer(0, 1, 1, 0, 32'h200, 4'hf, $random(seed));
                xfer(0, 0, 0, 0, 32'h200, 4'hf, '0);
                idle(0);
            end
            begin
                xfer(1, 0, 0, 0, 32'h1200, 4'hf, '0);
                xfer(1, 0, 0, 0, 32'h200, 4'hf, '0);
                idle(1);
            end
        join

        // big-endian access
        xfer(1, 1, 0, 1, 32'h1300, 4'b0011, 32'h1122_3344);
        xfer(1, 0, 0, 1, 32'h1300, 4'hf, '0);
        xfer(1, 0, 0, 0, 32'h1300, 4'hf, '0);
        idle(1);

        // decode errors
        xfer(0, 0, 0, 0, 32'h0001_0000, 4'hf, '0);
        xfer(1, 1, 0, 0, 32'h8000_0004, 4'hf, 32'hdead_beef);
        idle(0);
        idle(1);

        repeat (DLY + 3) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d responses never checked", exp_q.size());
            err_cnt++;
        end
        fails = i_tcb_lite_interconnect.i_chk.fail_cnt;
        $display("errors: %0d data mismatches, %0d assertion failures", err_cnt, fails);
        if (err_cnt == 0 && fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule: tcb_lite_interconnect_tb

//--- files.f
common/tcb_lite_pkg.sv
interconnect/tcb_lite_arbiter.sv
interconnect/tcb_lite_decoder.sv
source/tcb_lite_endian.sv
source/tcb_lite_interconnect.sv
testbench/tcb_lite_interconnect_chk.sv
testbench/tcb_lite_interconnect_tb.sv

//--- Bender.yml
package:
  name: tcb_lite_interconnect

sources:
  - common/tcb_lite_pkg.sv
  - interconnect/tcb_lite_arbiter.sv
  - interconnect/tcb_lite_decoder.sv
  - source/tcb_lite_endian.sv
  - source/tcb_lite_interconnect.sv
  - target: test
    files:
      - testbench/tcb_lite_interconnect_chk.sv
      - testbench/tcb_lite_interconnect_tb.sv
